// ==== gfx_pkg.sv ====
// ************************************************************************
// graphics package with canvas size, shape set, coordinate and colour
// types, and the pixel and framebuffer write structs
// ************************************************************************

`default_nettype none

package gfx_pkg;

    // widths
    localparam int CORDW    = 16;  // signed screen coordinate
    localparam int CIDXW    = 4;   // palette index
    localparam int FB_ADDRW = 16;  // linear framebuffer address

    // canvas
    localparam int FB_WIDTH  = 320;
    localparam int FB_HEIGHT = 180;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 57600 fits FB_ADDRW

    localparam int SHAPE_CNT = 32;  // nested rectangles per run

    typedef logic signed [CORDW-1:0]   coord_t;     // screen coordinate
    typedef logic [CIDXW-1:0]          cidx_t;      // palette index
    typedef logic [FB_ADDRW-1:0]       fb_addr_t;   // y*width + x
    typedef logic [$clog2(SHAPE_CNT):0] shape_id_t; // holds 0..SHAPE_CNT

    // corners of shape 0, each later shape moves one pixel inward
    localparam coord_t SHAPE_X0 = 16'sd60;
    localparam coord_t SHAPE_Y0 = 16'sd20;
    localparam coord_t SHAPE_X1 = 16'sd260;
    localparam coord_t SHAPE_Y1 = 16'sd160;

    // one drawn pixel
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

    // one framebuffer write
    typedef struct packed {
        fb_addr_t addr;
        cidx_t    cidx;
    } fb_wr_t;

endpackage

`default_nettype wire

// ==== draw_line.sv ====
// ************************************************************************
// Bresenham line engine, one pixel per enabled cycle, both endpoints
// drawn, start pulse in and done pulse out
// ************************************************************************

`default_nettype none
`timescale 1ns/1ps

module draw_line (
    input  wire logic            clk,      // clock
    input  wire logic            rst,      // sync reset
    input  wire logic            start,    // begin a line
    input  wire logic            oe,       // step enable
    input  wire gfx_pkg::coord_t x0,       // start point
    input  wire gfx_pkg::coord_t y0,
    input  wire gfx_pkg::coord_t x1,       // end point
    input  wire gfx_pkg::coord_t y1,
    output gfx_pkg::coord_t      x,        // current position
    output gfx_pkg::coord_t      y,
    output logic                 drawing,  // pixel presented this cycle
    output logic                 done      // one cycle after last pixel
);
    import gfx_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} line_state_t;
    line_state_t state;

    logic signed [CORDW+2:0] x0_w, y0_w, x1_w, y1_w;  // sign-extended ends
    logic signed [CORDW+2:0] dx_in, dy_in;  // from the ports at INIT
    logic signed [CORDW+2:0] dx, dy;        // dy kept negative
    logic signed [CORDW+2:0] err;           // running error term
    logic signed [CORDW+2:0] e2;            // doubled error
    logic signed [CORDW+2:0] err_nx;
    logic right;   // x steps up
    logic down;    // y steps up
    logic movx, movy;
    logic at_end;  // position equals end point

    always_comb begin
        x0_w = {{3{x0[CORDW-1]}}, x0};
        y0_w = {{3{y0[CORDW-1]}}, y0};
        x1_w = {{3{x1[CORDW-1]}}, x1};
        y1_w = {{3{y1[CORDW-1]}}, y1};
        dx_in = (x1_w >= x0_w) ? x1_w - x0_w : x0_w - x1_w;  // +|dx|
        dy_in = (y1_w >= y0_w) ? y0_w - y1_w : y1_w - y0_w;  // -|dy|
        e2 = err <<< 1;
        movx = (e2 >= dy);
        movy = (e2 <= dx);
        err_nx = err;
        if (movx) err_nx = err_nx + dy;
        if (movy) err_nx = err_nx + dx;
        at_end = (x == x1) && (y == y1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                INIT: begin  // load Bresenham state
                    x     <= x0;
                    y     <= y0;
                    dx    <= dx_in;
                    dy    <= dy_in;
                    err   <= dx_in + dy_in;
                    right <= (x1 >= x0);
                    down  <= (y1 >= y0);
                    state <= DRAW;
                end
                DRAW: begin
                    if (oe) begin  // hold position while oe low
                        if (at_end) begin
                            state <= DONE;  // last pixel out now
                        end else begin
                            if (movx) x <= right ? x + coord_t'(1) : x - coord_t'(1);
                            if (movy) y <= down ? y + coord_t'(1) : y - coord_t'(1);
                            err <= err_nx;
                        end
                    end
                end
                DONE: state <= IDLE;
                default: if (start) state <= INIT;  // IDLE
            endcase
        end
    end

    always_comb drawing = (state == DRAW) && oe;
    always_comb done    = (state == DONE);

    // endpoints held for the whole line, so x never leaves their span
    a_x_on_span: assert property (@(posedge clk) disable iff (rst)
        drawing |-> ((x >= x0 && x <= x1) || (x >= x1 && x <= x0)))
        else $error("draw_line x outside endpoint span");

endmodule

`default_nettype wire

// ==== draw_rect.sv ====
// ************************************************************************
// rectangle outline, four edges traced through draw_line in the order
// top, right, bottom, left
// ************************************************************************

`default_nettype none
`timescale 1ns/1ps

module draw_rect (
    input  wire logic            clk,      // clock
    input  wire logic            rst,      // sync reset
    input  wire logic            start,    // begin the outline
    input  wire logic            oe,       // step enable
    input  wire gfx_pkg::coord_t x0,       // top left corner
    input  wire gfx_pkg::coord_t y0,
    input  wire gfx_pkg::coord_t x1,       // bottom right corner
    input  wire gfx_pkg::coord_t y1,
    output gfx_pkg::coord_t      x,        // pixel position
    output gfx_pkg::coord_t      y,
    output logic                 drawing,  // pixel valid
    output logic                 done      // after fourth edge
);
    import gfx_pkg::*;

    typedef enum logic [2:0] {IDLE, TOP, RIGHT, BOTTOM, LEFT} edge_state_t;
    edge_state_t state;

    logic   line_start;  // one pulse per edge
    logic   line_done;
    coord_t lx0, ly0, lx1, ly1;

    // endpoints follow the edge state and stay put for the line
    always_comb begin
        case (state)
            RIGHT: begin  // down the right side
                lx0 = x1;
                ly0 = y0;
                lx1 = x1;
                ly1 = y1;
            end
            BOTTOM: begin  // right to left
                lx0 = x1;
                ly0 = y1;
                lx1 = x0;
                ly1 = y1;
            end
            LEFT: begin  // back up to the origin
                lx0 = x0;
                ly0 = y1;
                lx1 = x0;
                ly1 = y0;
            end
            default: begin  // top edge, also idle
                lx0 = x0;
                ly0 = y0;
                lx1 = x1;
                ly1 = y0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            line_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;  // pulses only
            done       <= 1'b0;
            case (state)
                TOP: begin
                    if (line_done) begin
                        state      <= RIGHT;
                        line_start <= 1'b1;
                    end
                end
                RIGHT: begin
                    if (line_done) begin
                        state      <= BOTTOM;
                        line_start <= 1'b1;
                    end
                end
                BOTTOM: begin
                    if (line_done) begin
                        state      <= LEFT;
                        line_start <= 1'b1;
                    end
                end
                LEFT: begin
                    if (line_done) begin
                        state <= IDLE;
                        done  <= 1'b1;  // outline complete
                    end
                end
                default: begin  // IDLE
                    if (start) begin
                        state      <= TOP;
                        line_start <= 1'b1;
                    end
                end
            endcase
        end
    end

    draw_line draw_line_inst (
        .clk,
        .rst,
        .start (line_start),
        .oe,
        .x0    (lx0),
        .y0    (ly0),
        .x1    (lx1),
        .y1    (ly1),
        .x,
        .y,
        .drawing,
        .done  (line_done)
    );

    // next edge only once the line engine has finished the last one
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        line_start |-> (!drawing && !line_done))
        else $error("draw_rect line_start while draw_line busy");

endmodule

`default_nettype wire

// ==== rect_renderer.sv ====
// ************************************************************************
// shape sequencer, one nested rectangle per shape id through draw_rect,
// registered pixel and valid out
// ************************************************************************

`default_nettype none
`timescale 1ns/1ps

module rect_renderer (
    input  wire logic       clk,        // clock
    input  wire logic       rst,        // sync reset
    input  wire logic       start,      // begin a full run
    input  wire logic       oe,         // step enable
    output gfx_pkg::pixel_t pix,        // drawn pixel
    output logic            pix_valid,  // pix holds a new pixel
    output logic            busy,       // run in progress
    output logic            done        // end of run pulse
);
    import gfx_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW} seq_state_t;
    seq_state_t state;

    shape_id_t shape_id;
    coord_t    vx0, vy0, vx1, vy1;  // corners of current shape
    cidx_t     cidx;
    logic      rect_start, rect_done;
    coord_t    rx, ry;              // raw draw position
    logic      rdrawing;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            shape_id   <= '0;
            rect_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            rect_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                INIT: begin  // corners one pixel inward per shape
                    vx0        <= SHAPE_X0 + coord_t'(shape_id);
                    vy0        <= SHAPE_Y0 + coord_t'(shape_id);
                    vx1        <= SHAPE_X1 - coord_t'(shape_id);
                    vy1        <= SHAPE_Y1 - coord_t'(shape_id);
                    cidx       <= shape_id[CIDXW-1:0];  // low bits pick colour
                    rect_start <= 1'b1;
                    state      <= DRAW;
                end
                DRAW: begin
                    if (rect_done) begin
                        if (shape_id == shape_id_t'(SHAPE_CNT - 1)) begin
                            done  <= 1'b1;
                            state <= IDLE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= INIT;
                        end
                    end
                end
                default: begin  // IDLE, start ignored elsewhere
                    if (start) begin
                        shape_id <= '0;
                        state    <= INIT;
                    end
                end
            endcase
        end
    end

    draw_rect draw_rect_inst (
        .clk,
        .rst,
        .start   (rect_start),
        .oe,
        .x0      (vx0),
        .y0      (vy0),
        .x1      (vx1),
        .y1      (vy1),
        .x       (rx),
        .y       (ry),
        .drawing (rdrawing),
        .done    (rect_done)
    );

    always_ff @(posedge clk) begin
        pix <= '{x: rx, y: ry, cidx: cidx};  // payload
    end

    always_ff @(posedge clk) begin
        if (rst) pix_valid <= 1'b0;
        else pix_valid <= rdrawing;
    end

    always_comb busy = (state != IDLE);

endmodule

`default_nettype wire

// ==== fb_writer.sv ====
// ************************************************************************
// framebuffer write pipeline, row base then linear address, 2 cycles
// ************************************************************************

`default_nettype none
`timescale 1ns/1ps

module fb_writer (
    input  wire logic            clk,        // clock
    input  wire logic            rst,        // sync reset
    input  wire gfx_pkg::pixel_t pix,        // drawn pixel
    input  wire logic            pix_valid,  // new pixel this cycle
    output logic                 wr,         // write strobe
    output gfx_pkg::fb_wr_t      wr_data     // address and colour
);
    import gfx_pkg::*;

    fb_addr_t row_base;  // y * FB_WIDTH
    fb_addr_t col;       // x
    cidx_t    cidx_s1;
    logic     valid_s1;

    // stage 1
    always_ff @(posedge clk) begin
        row_base <= fb_addr_t'(pix.y) * fb_addr_t'(FB_WIDTH);
        col      <= fb_addr_t'(pix.x);
        cidx_s1  <= pix.cidx;  // colour rides along
    end

    // stage 2
    always_ff @(posedge clk) begin
        wr_data <= '{addr: row_base + col, cidx: cidx_s1};
    end

    // valid bits, no stall so one pixel in per cycle at most
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
            wr       <= 1'b0;
        end else begin
            valid_s1 <= pix_valid;
            wr       <= valid_s1;
        end
    end

    // every shape sits on the canvas, so writes never pass its end
    a_addr_on_canvas: assert property (@(posedge clk) disable iff (rst)
        wr |-> (wr_data.addr < fb_addr_t'(FB_PIXELS)))
        else $error("fb_writer address beyond framebuffer");

endmodule

`default_nettype wire

// ==== rect_render_top.sv ====
// ************************************************************************
// rectangle render top, shape sequencer feeding the framebuffer writer
// ************************************************************************

`default_nettype none
`timescale 1ns/1ps

module rect_render_top (
    input  wire logic       clk,      // clock
    input  wire logic       rst,      // sync reset
    input  wire logic       start,    // begin a full run
    input  wire logic       oe,       // step enable
    output logic            wr,       // write strobe
    output gfx_pkg::fb_wr_t wr_data,  // address and colour
    output logic            busy,     // run in progress
    output logic            done      // may lead the last writes
);
    import gfx_pkg::*;

    pixel_t pix;        // renderer to writer
    logic   pix_valid;

    rect_renderer rect_renderer_inst (
        .clk,
        .rst,
        .start,
        .oe,
        .pix,
        .pix_valid,
        .busy,
        .done
    );

    fb_writer fb_writer_inst (
        .clk,
        .rst,
        .pix,
        .pix_valid,
        .wr,
        .wr_data
    );

endmodule

`default_nettype wire

// ==== tb_rect_render.sv ====
// ************************************************************************
// testbench for the rectangle render top, random oe and stray starts,
// every framebuffer write checked against a model of the outlines
// ************************************************************************

`default_nettype none
`timescale 1ns/1ps

module tb_rect_render;
    import gfx_pkg::*;

    localparam logic [31:0] SEED      = 32'hce50_443f;
    localparam int          RUN_LIMIT = 200000;  // cycles per run

    logic        clk;
    logic        rst;
    logic        start;
    logic        oe;
    logic        wr;
    fb_wr_t      wr_data;
    logic        busy;
    logic        done;

    logic [31:0] lcg_state;   // random source
    logic [2:0]  oe_hist;     // oe of the last three drives, [2] oldest
    fb_wr_t      exp_q[$];    // expected writes of one run

    rect_render_top dut (
        .clk,
        .rst,
        .start,
        .oe,
        .wr,
        .wr_data,
        .busy,
        .done
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one write of the model, address from the raster rule
    function automatic fb_wr_t make_wr(input int px, input int py, input int id);
        fb_wr_t w;
        w.addr = fb_addr_t'(py * FB_WIDTH + px);
        w.cidx = cidx_t'(id % 16);
        return w;
    endfunction

    // outlines in edge order, corners written twice
    task automatic build_model();
        int x0;
        int y0;
        int x1;
        int y1;
        exp_q.delete();
        for (int id = 0; id < SHAPE_CNT; id++) begin
            x0 = 60 + id;
            y0 = 20 + id;
            x1 = 260 - id;
            y1 = 160 - id;
            for (int px = x0; px <= x1; px++) exp_q.push_back(make_wr(px, y0, id));  // top
            for (int py = y0; py <= y1; py++) exp_q.push_back(make_wr(x1, py, id));  // right
            for (int px = x1; px >= x0; px--) exp_q.push_back(make_wr(px, y1, id));  // bottom
            for (int py = y1; py >= y0; py--) exp_q.push_back(make_wr(x0, py, id));  // left
        end
    endtask

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_wr(input string name, input fb_wr_t got, input fb_wr_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got addr %h cidx %h expected addr %h cidx %h",
                     name, got.addr, got.cidx, exp.addr, exp.cidx);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    // new oe each cycle, rare start when allowed
    task automatic drive_inputs(input logic allow_start);
        lcg_state = lcg(lcg_state);
        oe        = (lcg_state[31:24] < 8'd154);  // about 60 % high
        start     = allow_start && (lcg_state[15:10] == 6'd0);
        oe_hist   = {oe_hist[1:0], oe};
    endtask

    // nothing may happen without a run
    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            check_flag("wr", wr, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            drive_inputs(1'b0);
            @(negedge clk);
        end
    endtask

    // one full run, writes in model order until done and count match
    task automatic run_render();
        int   idx;
        int   cycles;
        logic seen_done;
        idx       = 0;
        cycles    = 0;
        seen_done = 1'b0;
        drive_inputs(1'b0);
        start = 1'b1;
        @(negedge clk);
        while (!(seen_done && idx == exp_q.size())) begin
            if (wr) begin
                check_flag("oe three cycles before wr", oe_hist[2], 1'b1);
                if (idx >= exp_q.size()) begin
                    $display("more framebuffer writes than the model holds");
                    abort_run();
                end
                check_wr("wr_data", wr_data, exp_q[idx]);
                idx++;
            end
            if (seen_done) begin  // single pulse, busy stays low
                check_flag("done", done, 1'b0);
                check_flag("busy", busy, 1'b0);
            end else if (done) begin
                check_flag("busy", busy, 1'b0);  // falls with done
                seen_done = 1'b1;
            end else begin
                check_flag("busy", busy, 1'b1);
            end
            drive_inputs(!seen_done && busy);  // stray starts mid run
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) report_timeout("end of run and last write");
        end
        $display("run finished with %0d writes in %0d cycles", idx, cycles);
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        oe        = 1'b0;
        oe_hist   = '0;
        lcg_state = SEED;
        build_model();
        repeat (5) @(negedge clk);  // five reset cycles
        rst = 1'b0;
        check_idle(20);
        run_render();
        check_idle(10);  // drain, no extra writes
        run_render();    // second run gives the same list
        check_idle(10);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
gfx_pkg.sv
draw_line.sv
draw_rect.sv
rect_renderer.sv
fb_writer.sv
rect_render_top.sv
tb_rect_render.sv

// ==== Makefile ====
TOP = tb_rect_render

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
